// File: include/gpio_params.svh
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// Pin count of the port
`define GPIO_PIN_W        8

// AXI-Lite bus widths
`define GPIO_ADDR_W       32
`define GPIO_DATA_W       32
`define GPIO_STRB_W       4
`define GPIO_PROT_W       3
`define GPIO_RESP_W       2

// Register map
`define GPIO_BASE_ADDR    (32'h0200_7000)
`define GPIO_OFS_CFG      (32'h0000_0000)
`define GPIO_OFS_DOUT     (32'h0000_0004)
`define GPIO_OFS_DIN      (32'h0000_0008)

// Response codes
`define GPIO_RESP_OKAY    (2'b00)
`define GPIO_RESP_DECERR  (2'b11)

`endif

// File: hdl/gpio_pkg.sv
`default_nettype none

`include "gpio_params.svh"

package gpio_pkg;

    ////////////////////
    // Register word views
    ////////////////////

    // Config word, direction in the low byte
    typedef struct packed {
        logic [`GPIO_DATA_W-`GPIO_PIN_W-2:0] reserved;
        logic                                latch_en;
        logic [`GPIO_PIN_W-1:0]              dir;
    } gpio_cfg_t;

    // Output data word
    typedef struct packed {
        logic [`GPIO_DATA_W-`GPIO_PIN_W-1:0] reserved;
        logic [`GPIO_PIN_W-1:0]              data;
    } gpio_dout_t;

    // One bus word, read as config or output data by address
    typedef union packed {
        gpio_cfg_t                cfg;
        gpio_dout_t               dout;
        logic [`GPIO_DATA_W-1:0]  raw;
    } gpio_word_u;

    ////////////////////
    // Decode and request
    ////////////////////

    typedef enum logic [1:0] {
        REG_CFG  = 2'd0,
        REG_DOUT = 2'd1,
        REG_DIN  = 2'd2,
        REG_NONE = 2'd3
    } gpio_reg_e;

    typedef struct packed {
        logic       en;
        gpio_reg_e  sel;
        gpio_word_u word;
    } gpio_wr_req_t;

endpackage

`default_nettype wire

// File: hdl/gpio_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_axi_slave (
    input  wire                          clk_i,
    input  wire                          resetn_i,

    // Write address channel
    input  wire  [`GPIO_ADDR_W-1:0]      s_awaddr_i,
    input  wire  [`GPIO_PROT_W-1:0]      s_awprot_i,
    input  wire                          s_awvalid_i,
    output logic                         s_awready_o,

    // Write data channel
    input  wire  [`GPIO_DATA_W-1:0]      s_wdata_i,
    input  wire  [`GPIO_STRB_W-1:0]      s_wstrb_i,
    input  wire                          s_wvalid_i,
    output logic                         s_wready_o,

    // Write response channel
    output logic [`GPIO_RESP_W-1:0]      s_bresp_o,
    output logic                         s_bvalid_o,
    input  wire                          s_bready_i,

    // Read address channel
    input  wire  [`GPIO_ADDR_W-1:0]      s_araddr_i,
    input  wire  [`GPIO_PROT_W-1:0]      s_arprot_i,
    input  wire                          s_arvalid_i,
    output logic                         s_arready_o,

    // Read data channel
    output logic [`GPIO_DATA_W-1:0]      s_rdata_o,
    output logic [`GPIO_RESP_W-1:0]      s_rresp_o,
    output logic                         s_rvalid_o,
    input  wire                          s_rready_i,

    // Register block side
    output gpio_pkg::gpio_wr_req_t       wr_req_o,
    output gpio_pkg::gpio_reg_e          rd_sel_o,
    input  wire  [`GPIO_DATA_W-1:0]      rd_data_i
);

    logic                      awready_q;
    logic                      bvalid_q;
    logic [`GPIO_RESP_W-1:0]   bresp_q;
    logic                      arready_q;
    logic                      rvalid_q;
    logic [`GPIO_DATA_W-1:0]   rdata_q;
    logic [`GPIO_RESP_W-1:0]   rresp_q;
    gpio_pkg::gpio_reg_e       wr_sel;
    gpio_pkg::gpio_reg_e       ar_sel;
    logic                      wr_ok;

    // Full address match, anything else is unmapped
    function automatic gpio_pkg::gpio_reg_e decode_addr(input logic [`GPIO_ADDR_W-1:0] addr);
        gpio_pkg::gpio_reg_e sel;
        case (addr)
            `GPIO_BASE_ADDR + `GPIO_OFS_CFG:  sel = gpio_pkg::REG_CFG;
            `GPIO_BASE_ADDR + `GPIO_OFS_DOUT: sel = gpio_pkg::REG_DOUT;
            `GPIO_BASE_ADDR + `GPIO_OFS_DIN:  sel = gpio_pkg::REG_DIN;
            default:                          sel = gpio_pkg::REG_NONE;
        endcase
        return sel;
    endfunction

    assign wr_sel = decode_addr(s_awaddr_i);
    assign ar_sel = decode_addr(s_araddr_i);

    // Only config and output data take writes
    assign wr_ok = (wr_sel == gpio_pkg::REG_CFG) || (wr_sel == gpio_pkg::REG_DOUT);

    always_comb begin
        wr_req_o.en       = awready_q && wr_ok;
        wr_req_o.sel      = wr_sel;
        wr_req_o.word.raw = s_wdata_i;
    end

    // Select is live only in the arready cycle
    assign rd_sel_o = arready_q ? ar_sel : gpio_pkg::REG_NONE;

    ////////////////////
    // Write path
    ////////////////////

    // Address and data accepted together, one response pending at most
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            awready_q <= s_awvalid_i && s_wvalid_i && !bvalid_q && !awready_q;
            if (awready_q) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (awready_q) begin
            bresp_q <= wr_ok ? `GPIO_RESP_OKAY : `GPIO_RESP_DECERR;
        end
    end

    ////////////////////
    // Read path
    ////////////////////

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= s_arvalid_i && !rvalid_q && !arready_q;
            if (arready_q) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Unmapped reads see zero from the mux
    always_ff @(posedge clk_i) begin
        if (arready_q) begin
            rdata_q <= rd_data_i;
            rresp_q <= (ar_sel == gpio_pkg::REG_NONE) ? `GPIO_RESP_DECERR : `GPIO_RESP_OKAY;
        end
    end

    assign s_awready_o = awready_q;
    assign s_wready_o  = awready_q;
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = bresp_q;
    assign s_arready_o = arready_q;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = rresp_q;

    ////////////////////
    // Protocol checks
    ////////////////////

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

    a_rdata_stable: assert property (@(posedge clk_i) disable iff (!resetn_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

    // Back-pressure holds off the next write
    a_no_accept_during_b: assert property (@(posedge clk_i) disable iff (!resetn_i)
        !(s_awready_o && s_bvalid_o));

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_regs (
    input  wire                          clk_i,
    input  wire                          resetn_i,
    input  wire gpio_pkg::gpio_wr_req_t  wr_req_i,
    input  wire gpio_pkg::gpio_reg_e     rd_sel_i,
    output logic [`GPIO_DATA_W-1:0]      rd_data_o,
    input  wire  [`GPIO_PIN_W-1:0]       din_i,
    output logic [`GPIO_PIN_W-1:0]       dir_o,
    output logic                         latch_en_o,
    output logic [`GPIO_PIN_W-1:0]       dout_o
);

    logic [`GPIO_PIN_W-1:0]  dir_q;
    logic                    latch_en_q;
    logic [`GPIO_PIN_W-1:0]  dout_q;
    gpio_pkg::gpio_word_u    rd_word;

    // Config and output data, each taken through its own view of the word
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            dir_q      <= '0;
            latch_en_q <= 1'b0;
            dout_q     <= '0;
        end else if (wr_req_i.en) begin
            if (wr_req_i.sel == gpio_pkg::REG_CFG) begin
                dir_q      <= wr_req_i.word.cfg.dir;
                latch_en_q <= wr_req_i.word.cfg.latch_en;
            end else if (wr_req_i.sel == gpio_pkg::REG_DOUT) begin
                dout_q <= wr_req_i.word.dout.data;
            end
        end
    end

    // Readback, reserved bits read as zero
    always_comb begin
        rd_word = '0;
        case (rd_sel_i)
            gpio_pkg::REG_CFG: begin
                rd_word.cfg.dir      = dir_q;
                rd_word.cfg.latch_en = latch_en_q;
            end
            gpio_pkg::REG_DOUT: begin
                rd_word.dout.data = dout_q;
            end
            gpio_pkg::REG_DIN: begin
                rd_word.raw[`GPIO_PIN_W-1:0] = din_i;
            end
            default: begin
                rd_word.raw = '0;
            end
        endcase
    end

    assign rd_data_o  = rd_word.raw;
    assign dir_o      = dir_q;
    assign latch_en_o = latch_en_q;
    assign dout_o     = dout_q;

    // Input register is read-only, the slave must filter it
    a_no_din_write: assert property (@(posedge clk_i) disable iff (!resetn_i)
        wr_req_i.en |-> wr_req_i.sel != gpio_pkg::REG_DIN);

endmodule

`default_nettype wire

// File: hdl/gpio_pins.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_pins (
    input  wire                      clk_i,
    input  wire                      resetn_i,
    input  wire  [`GPIO_PIN_W-1:0]   dir_i,
    input  wire                      latch_en_i,
    input  wire  [`GPIO_PIN_W-1:0]   dout_i,
    input  wire  [`GPIO_PIN_W-1:0]   gpio_i,
    output logic [`GPIO_PIN_W-1:0]   gpio_o,
    output logic [`GPIO_PIN_W-1:0]   gpio_oe_o,
    output logic [`GPIO_PIN_W-1:0]   din_sync_o
);

    logic [`GPIO_PIN_W-1:0]  latch_q;
    logic [`GPIO_PIN_W-1:0]  sync1_q;
    logic [`GPIO_PIN_W-1:0]  sync2_q;

    // Output latch follows dout while enabled, else holds
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            latch_q <= '0;
        end else if (latch_en_i) begin
            latch_q <= dout_i;
        end
    end

    // Two-flop synchronizer on the pin inputs
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
        end
    end

    // Tri-state lives in the pad ring
    assign gpio_o     = latch_q;
    assign gpio_oe_o  = dir_i;
    assign din_sync_o = sync2_q;

endmodule

`default_nettype wire

// File: hdl/gpio_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_axi_top (
    input  wire                       clk_i,
    input  wire                       resetn_i,

    // AXI-Lite slave port
    input  wire  [`GPIO_ADDR_W-1:0]   s_awaddr_i,
    input  wire  [`GPIO_PROT_W-1:0]   s_awprot_i,
    input  wire                       s_awvalid_i,
    output wire                       s_awready_o,
    input  wire  [`GPIO_DATA_W-1:0]   s_wdata_i,
    input  wire  [`GPIO_STRB_W-1:0]   s_wstrb_i,
    input  wire                       s_wvalid_i,
    output wire                       s_wready_o,
    output wire  [`GPIO_RESP_W-1:0]   s_bresp_o,
    output wire                       s_bvalid_o,
    input  wire                       s_bready_i,
    input  wire  [`GPIO_ADDR_W-1:0]   s_araddr_i,
    input  wire  [`GPIO_PROT_W-1:0]   s_arprot_i,
    input  wire                       s_arvalid_i,
    output wire                       s_arready_o,
    output wire  [`GPIO_DATA_W-1:0]   s_rdata_o,
    output wire  [`GPIO_RESP_W-1:0]   s_rresp_o,
    output wire                       s_rvalid_o,
    input  wire                       s_rready_i,

    // Pins toward the pad ring
    input  wire  [`GPIO_PIN_W-1:0]    gpio_i,
    output wire  [`GPIO_PIN_W-1:0]    gpio_o,
    output wire  [`GPIO_PIN_W-1:0]    gpio_oe_o
);

    gpio_pkg::gpio_wr_req_t    wr_req;
    gpio_pkg::gpio_reg_e       rd_sel;
    logic [`GPIO_DATA_W-1:0]   rd_data;
    logic [`GPIO_PIN_W-1:0]    dir;
    logic                      latch_en;
    logic [`GPIO_PIN_W-1:0]    dout;
    logic [`GPIO_PIN_W-1:0]    din_sync;

    gpio_axi_slave slave_i (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awprot_i  (s_awprot_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arprot_i  (s_arprot_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .wr_req_o    (wr_req),
        .rd_sel_o    (rd_sel),
        .rd_data_i   (rd_data)
    );

    gpio_regs regs_i (
        .clk_i      (clk_i),
        .resetn_i   (resetn_i),
        .wr_req_i   (wr_req),
        .rd_sel_i   (rd_sel),
        .rd_data_o  (rd_data),
        .din_i      (din_sync),
        .dir_o      (dir),
        .latch_en_o (latch_en),
        .dout_o     (dout)
    );

    gpio_pins pins_i (
        .clk_i      (clk_i),
        .resetn_i   (resetn_i),
        .dir_i      (dir),
        .latch_en_i (latch_en),
        .dout_i     (dout),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o),
        .gpio_oe_o  (gpio_oe_o),
        .din_sync_o (din_sync)
    );

endmodule

`default_nettype wire

// File: sim/gpio_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_checker (
    input  wire                      clk_i,
    input  wire                      resetn_i,
    input  wire  [`GPIO_ADDR_W-1:0]  awaddr_i,
    input  wire                      awvalid_i,
    input  wire                      awready_i,
    input  wire  [`GPIO_DATA_W-1:0]  wdata_i,
    input  wire                      wvalid_i,
    input  wire                      wready_i,
    input  wire  [`GPIO_RESP_W-1:0]  bresp_i,
    input  wire                      bvalid_i,
    input  wire                      bready_i,
    input  wire  [`GPIO_ADDR_W-1:0]  araddr_i,
    input  wire                      arvalid_i,
    input  wire                      arready_i,
    input  wire  [`GPIO_DATA_W-1:0]  rdata_i,
    input  wire  [`GPIO_RESP_W-1:0]  rresp_i,
    input  wire                      rvalid_i,
    input  wire                      rready_i,
    input  wire  [`GPIO_PIN_W-1:0]   gpio_in_i,
    input  wire  [`GPIO_PIN_W-1:0]   gpio_out_i,
    input  wire  [`GPIO_PIN_W-1:0]   gpio_oe_i,
    output int                       error_count_o,
    output int                       check_count_o
);

    localparam logic [`GPIO_ADDR_W-1:0] cfg_addr  = `GPIO_BASE_ADDR + `GPIO_OFS_CFG;
    localparam logic [`GPIO_ADDR_W-1:0] dout_addr = `GPIO_BASE_ADDR + `GPIO_OFS_DOUT;
    localparam logic [`GPIO_ADDR_W-1:0] din_addr  = `GPIO_BASE_ADDR + `GPIO_OFS_DIN;

    // Model of the register block and the output latch
    logic [`GPIO_PIN_W-1:0]   m_dir;
    logic                     m_latch_en;
    logic [`GPIO_PIN_W-1:0]   m_dout;
    logic [`GPIO_PIN_W-1:0]   m_latch;
    logic                     b_pending;
    logic [`GPIO_RESP_W-1:0]  b_exp;
    logic                     r_pending;
    logic [`GPIO_RESP_W-1:0]  r_exp_resp;
    logic [`GPIO_DATA_W-1:0]  r_exp_data;
    logic                     b_wait_q;
    logic [`GPIO_RESP_W-1:0]  b_resp_q;
    logic                     r_wait_q;
    logic [`GPIO_DATA_W-1:0]  r_data_q;
    logic                     in_reset_q;
    int                       error_count = 0;
    int                       check_count = 0;

    assign error_count_o = error_count;
    assign check_count_o = check_count;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [`GPIO_RESP_W-1:0] expected_write_resp(
        input logic [`GPIO_ADDR_W-1:0] addr
    );
        if (addr == cfg_addr || addr == dout_addr) begin
            return `GPIO_RESP_OKAY;
        end
        return `GPIO_RESP_DECERR;
    endfunction

    // Response in the top two bits and read data below
    function automatic logic [`GPIO_RESP_W+`GPIO_DATA_W-1:0] expected_read(
        input logic [`GPIO_ADDR_W-1:0] addr
    );
        gpio_pkg::gpio_word_u     word;
        logic [`GPIO_RESP_W-1:0]  resp;
        word.raw = '0;
        resp = `GPIO_RESP_OKAY;
        if (addr == cfg_addr) begin
            word.cfg.dir      = m_dir;
            word.cfg.latch_en = m_latch_en;
        end else if (addr == dout_addr) begin
            word.dout.data = m_dout;
        end else if (addr == din_addr) begin
            word.raw[`GPIO_PIN_W-1:0] = gpio_in_i;
        end else begin
            resp = `GPIO_RESP_DECERR;
        end
        return {resp, word.raw};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("failure: %s at %0t", what, $time);
    endtask

    ////////////////////
    // Comparison
    ////////////////////

    always @(posedge clk_i or negedge resetn_i) begin
        gpio_pkg::gpio_word_u                   wr_word;
        logic [`GPIO_RESP_W+`GPIO_DATA_W-1:0]   rd_exp;
        if (!resetn_i) begin
            m_dir      <= '0;
            m_latch_en <= 1'b0;
            m_dout     <= '0;
            m_latch    <= '0;
            b_pending  <= 1'b0;
            r_pending  <= 1'b0;
            b_wait_q   <= 1'b0;
            r_wait_q   <= 1'b0;
            in_reset_q <= 1'b1;
        end else begin
            wr_word.raw = wdata_i;
            rd_exp = expected_read(araddr_i);
            in_reset_q <= 1'b0;

            // Nothing has moved yet on the first edge after reset
            if (in_reset_q) begin
                compare_value("gpio_o", 32'(gpio_out_i), 32'h0);
                compare_value("gpio_oe_o", 32'(gpio_oe_i), 32'h0);
                compare_value("awready wready bvalid arready rvalid",
                              32'({awready_i, wready_i, bvalid_i, arready_i, rvalid_i}),
                              32'h0);
            end

            if (m_latch_en) begin
                m_latch <= m_dout;
            end

            if (awready_i !== wready_i) begin
                report_failure("awready and wready did not pulse together");
            end

            if (bvalid_i && bready_i) begin
                if (!b_pending) begin
                    report_failure("write response without an accepted write");
                end
                compare_value("bresp", 32'(bresp_i), 32'(b_exp));
                compare_value("gpio_oe_o", 32'(gpio_oe_i), 32'(m_dir));
                compare_value("gpio_o", 32'(gpio_out_i & m_dir), 32'(m_latch & m_dir));
                b_pending <= 1'b0;
            end

            if (awready_i && wready_i && awvalid_i && wvalid_i) begin
                if (b_pending) begin
                    report_failure("write accepted while a write response was pending");
                end
                b_pending <= 1'b1;
                b_exp     <= expected_write_resp(awaddr_i);
                if (awaddr_i == cfg_addr) begin
                    m_dir      <= wr_word.cfg.dir;
                    m_latch_en <= wr_word.cfg.latch_en;
                end else if (awaddr_i == dout_addr) begin
                    m_dout <= wr_word.dout.data;
                end
            end

            if (rvalid_i && rready_i) begin
                if (!r_pending) begin
                    report_failure("read response without an accepted read");
                end
                compare_value("rresp", 32'(rresp_i), 32'(r_exp_resp));
                if (r_exp_resp == `GPIO_RESP_OKAY) begin
                    compare_value("rdata", rdata_i, r_exp_data);
                end
                r_pending <= 1'b0;
            end

            if (arready_i && arvalid_i) begin
                if (r_pending) begin
                    report_failure("read accepted while a read response was pending");
                end
                r_pending  <= 1'b1;
                r_exp_resp <= rd_exp[`GPIO_RESP_W+`GPIO_DATA_W-1:`GPIO_DATA_W];
                r_exp_data <= rd_exp[`GPIO_DATA_W-1:0];
            end

            // Responses must hold while the master stalls
            if (b_wait_q && (!bvalid_i || bresp_i != b_resp_q)) begin
                report_failure("bvalid dropped or bresp changed before bready");
            end
            if (r_wait_q && (!rvalid_i || rdata_i != r_data_q)) begin
                report_failure("rvalid dropped or rdata changed before rready");
            end
            b_wait_q <= bvalid_i && !bready_i;
            b_resp_q <= bresp_i;
            r_wait_q <= rvalid_i && !rready_i;
            r_data_q <= rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module tb_gpio;

    localparam int timeout_cycles = 200;
    localparam logic [`GPIO_ADDR_W-1:0] cfg_addr  = `GPIO_BASE_ADDR + `GPIO_OFS_CFG;
    localparam logic [`GPIO_ADDR_W-1:0] dout_addr = `GPIO_BASE_ADDR + `GPIO_OFS_DOUT;
    localparam logic [`GPIO_ADDR_W-1:0] din_addr  = `GPIO_BASE_ADDR + `GPIO_OFS_DIN;
    localparam logic [`GPIO_ADDR_W-1:0] hole_addr = `GPIO_BASE_ADDR + 32'h0000_000c;

    logic                      clk_i;
    logic                      resetn_i;
    logic [`GPIO_ADDR_W-1:0]   s_awaddr_i;
    logic [`GPIO_PROT_W-1:0]   s_awprot_i;
    logic                      s_awvalid_i;
    logic                      s_awready_o;
    logic [`GPIO_DATA_W-1:0]   s_wdata_i;
    logic [`GPIO_STRB_W-1:0]   s_wstrb_i;
    logic                      s_wvalid_i;
    logic                      s_wready_o;
    logic [`GPIO_RESP_W-1:0]   s_bresp_o;
    logic                      s_bvalid_o;
    logic                      s_bready_i;
    logic [`GPIO_ADDR_W-1:0]   s_araddr_i;
    logic [`GPIO_PROT_W-1:0]   s_arprot_i;
    logic                      s_arvalid_i;
    logic                      s_arready_o;
    logic [`GPIO_DATA_W-1:0]   s_rdata_o;
    logic [`GPIO_RESP_W-1:0]   s_rresp_o;
    logic                      s_rvalid_o;
    logic                      s_rready_i;
    logic [`GPIO_PIN_W-1:0]    gpio_i;
    logic [`GPIO_PIN_W-1:0]    gpio_o;
    logic [`GPIO_PIN_W-1:0]    gpio_oe_o;
    int                        error_count;
    int                        check_count;

    gpio_axi_top dut_i (.*);

    gpio_checker checker_i (
        .clk_i         (clk_i),
        .resetn_i      (resetn_i),
        .awaddr_i      (s_awaddr_i),
        .awvalid_i     (s_awvalid_i),
        .awready_i     (s_awready_o),
        .wdata_i       (s_wdata_i),
        .wvalid_i      (s_wvalid_i),
        .wready_i      (s_wready_o),
        .bresp_i       (s_bresp_o),
        .bvalid_i      (s_bvalid_o),
        .bready_i      (s_bready_i),
        .araddr_i      (s_araddr_i),
        .arvalid_i     (s_arvalid_i),
        .arready_i     (s_arready_o),
        .rdata_i       (s_rdata_o),
        .rresp_i       (s_rresp_o),
        .rvalid_i      (s_rvalid_o),
        .rready_i      (s_rready_i),
        .gpio_in_i     (gpio_i),
        .gpio_out_i    (gpio_o),
        .gpio_oe_i     (gpio_oe_o),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    ////////////////////
    // AXI-Lite master
    ////////////////////

    task automatic abort_run(input string what);
        $display("timeout: %s at %0t", what, $time);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic present_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        #2;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
    endtask

    // Valids drop after the accept cycle seen at the falling edge
    task automatic wait_write_accept();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!s_awready_o && cycles < timeout_cycles);
        if (!s_awready_o) begin
            abort_run("write address and data never accepted");
        end
        @(posedge clk_i);
        #2;
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
    endtask

    task automatic finish_write(input int stall);
        int cycles;
        cycles = 0;
        while (!s_bvalid_o && cycles < timeout_cycles) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!s_bvalid_o) begin
            abort_run("write response never arrived");
        end
        repeat (stall) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        s_bready_i = 1'b1;
        @(posedge clk_i);
        #2;
        s_bready_i = 1'b0;
    endtask

    task automatic present_read(input logic [31:0] addr);
        @(posedge clk_i);
        #2;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
    endtask

    task automatic wait_read_accept();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!s_arready_o && cycles < timeout_cycles);
        if (!s_arready_o) begin
            abort_run("read address never accepted");
        end
        @(posedge clk_i);
        #2;
        s_arvalid_i = 1'b0;
    endtask

    task automatic finish_read(input int stall);
        int cycles;
        cycles = 0;
        while (!s_rvalid_o && cycles < timeout_cycles) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!s_rvalid_o) begin
            abort_run("read response never arrived");
        end
        repeat (stall) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        s_rready_i = 1'b1;
        @(posedge clk_i);
        #2;
        s_rready_i = 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        present_write(addr, data);
        wait_write_accept();
        finish_write(0);
    endtask

    task automatic axi_read(input logic [31:0] addr);
        present_read(addr);
        wait_read_accept();
        finish_read(0);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        gpio_pkg::gpio_word_u  word;
        logic [31:0]           rnd;
        int                    i;
        resetn_i    = 1'b0;
        s_awaddr_i  = '0;
        s_awprot_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '1;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arprot_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        gpio_i      = '0;
        rnd = $urandom(32'h0a79_44cd);
        repeat (3) @(posedge clk_i);
        #2;
        resetn_i = 1'b1;

        // Reset values
        axi_read(cfg_addr);
        axi_read(dout_addr);

        // Random register contents including reserved bits
        for (i = 0; i < 16; i++) begin
            axi_write(cfg_addr, $urandom);
            axi_read(cfg_addr);
            axi_write(dout_addr, $urandom);
            axi_read(dout_addr);
        end

        // Latch follows output data and holds once disabled
        word = '0;
        word.cfg.dir      = '1;
        word.cfg.latch_en = 1'b1;
        axi_write(cfg_addr, word.raw);
        axi_write(dout_addr, 32'h0000_00a5);
        word.cfg.latch_en = 1'b0;
        axi_write(cfg_addr, word.raw);
        axi_write(dout_addr, 32'h0000_005a);
        axi_write(dout_addr, 32'h0000_00c3);
        axi_read(dout_addr);

        // Pins held long enough to pass the synchronizer
        for (i = 0; i < 8; i++) begin
            rnd = $urandom;
            @(posedge clk_i);
            #2;
            gpio_i = rnd[`GPIO_PIN_W-1:0];
            repeat (4) @(posedge clk_i);
            axi_read(din_addr);
        end

        // Unmapped and read-only targets
        axi_write(hole_addr, $urandom);
        axi_write(din_addr, $urandom);
        axi_write(32'h0000_0000, $urandom);
        axi_read(hole_addr);
        axi_read(32'h0200_8000);
        axi_read(cfg_addr);
        axi_read(dout_addr);

        // A second request waits behind a stalled response
        for (i = 0; i < 4; i++) begin
            present_write(cfg_addr, $urandom);
            wait_write_accept();
            present_write(dout_addr, $urandom);
            finish_write($urandom_range(8, 1));
            wait_write_accept();
            finish_write(0);
            present_read(cfg_addr);
            wait_read_accept();
            present_read(dout_addr);
            finish_read($urandom_range(8, 1));
            wait_read_accept();
            finish_read(0);
        end

        repeat (4) @(posedge clk_i);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
hdl/gpio_pkg.sv
hdl/gpio_axi_slave.sv
hdl/gpio_regs.sv
hdl/gpio_pins.sv
hdl/gpio_axi_top.sv
sim/gpio_checker.sv
sim/tb_gpio.sv

// File: run.sh
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_gpio -o tb_gpio_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_gpio_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
